// File: verilog.f
logic/invaders_pkg.sv
logic/cabinet_if.sv
logic/control_decoder.sv
logic/cabinet_config.sv
logic/input_port_mux.sv
logic/port_trigger_router.sv
logic/invaders_io_top.sv
bench/tb_invaders_io.sv

// File: Bender.yml
package:
  name: invaders_io

sources:
  - logic/invaders_pkg.sv
  - logic/cabinet_if.sv
  - logic/control_decoder.sv
  - logic/cabinet_config.sv
  - logic/input_port_mux.sv
  - logic/port_trigger_router.sv
  - logic/invaders_io_top.sv
  - target: simulation
    files:
      - bench/tb_invaders_io.sv

// File: bench/tb_invaders_io.sv
// Invaders I/O testbench driving keys, joysticks, downloads and port writes against a model
`timescale 1ns/1ps

module tb_invaders_io;

        import invaders_pkg::*;

        logic                 clk_sys;
        logic                 reset;
        logic [PS2_W-1:0]     ps2_key;
        logic [JOY_W-1:0]     joy1;
        logic [JOY_W-1:0]     joy2;
        logic                 ioctl_wr;
        logic [7:0]           ioctl_index;
        logic [DL_ADDR_W-1:0] ioctl_addr;
        logic [7:0]           ioctl_dout;
        logic                 wide_aspect;
        logic                 horizontal_view;
        logic [7:0]           shifter_data;
        logic                 shift_reverse;
        logic [7:0]           port_wr;
        logic [7:0]           port0, port1, port2, port3;
        logic                 shift_count, shift_data, audio_p1, audio_p2, watchdog_kick;
        logic                 landscape, rotate_ccw, watchdog_enable;
        logic [7:0]           hdmi_arx, hdmi_ary;

        // Model state: slots 0..5 p1, 6..11 p2, 12 coin1, 13 coin2, 14 start1, 15 start2
        logic [15:0]  kb;
        logic         key_tgl;
        logic [7:0]   m_game;
        logic [7:0]   m_dip [0:3];
        logic         check_en;
        logic [55:0]  exp_vec;
        int           errors;
        int           checks;
        int           g;
        int           b;
        logic [31:0]  r;
        logic [8:0]   code;
        logic         tgl;

        // Known scan codes, including the four fire c/d keys that drive nothing
        logic [183:0] code_list = 184'h1D2129121B1C34232B2D11141E0616053676_2E746B7275;
        logic [39:0]  game_list = {8'd7, 8'd15, 8'd14, 8'd5, 8'd0};

        invaders_io_top uut (.*);

        initial
        begin
                clk_sys = 1'b0;
                forever #5 clk_sys = ~clk_sys;
        end

        ////////////////////////////////////////
        // Reference model
        ////////////////////////////////////////
        function automatic int key_slot(input logic [8:0] c);
                case (c)
                9'h074: return 0;
                9'h06B: return 1;
                9'h072: return 2;
                9'h075: return 3;
                9'h014: return 4;
                9'h011: return 5;
                9'h034: return 6;
                9'h023: return 7;
                9'h02B: return 8;
                9'h02D: return 9;
                9'h01C: return 10;
                9'h01B: return 11;
                9'h076, 9'h02E: return 12;
                9'h036: return 13;
                9'h005, 9'h016: return 14;
                9'h006, 9'h01E: return 15;
                default: return -1;
                endcase
        endfunction

        function automatic logic [7:0] bit_reverse(input logic [7:0] v);
                logic [7:0] res;
                for (int i = 0; i < 8; i++)
                        res[i] = v[7 - i];
                return res;
        endfunction

        // Packed as port0..port3, count, data, audio1, audio2, kick, flags, aspect x/y
        function automatic logic [55:0] expected_outputs();
                logic [15:0] joy_any;
                logic [5:0]  p1, p2;
                logic        start1, start2, coin, right, left, fire_a;
                logic [7:0]  x0, x1, x2, x3, ax, ay;
                logic [4:0]  trg;
                logic        land, rot, wd;
                joy_any = joy1 | joy2;
                p1      = kb[5:0] | joy1[5:0];
                p2      = kb[11:6] | joy2[5:0];
                start1  = kb[14] | joy_any[8];
                start2  = kb[15] | joy_any[9];
                coin    = kb[12] | kb[13] | joy_any[10];
                right   = p1[0] | p2[0];
                left    = p1[1] | p2[1];
                fire_a  = p1[4] | p2[4];
                x0 = 8'hFF;
                x1 = 8'hFF;
                x2 = 8'hFF;
                x3 = shifter_data;
                case (m_game)
                8'd0:
                begin
                        x0 = m_dip[0] | {1'b1, right, left, fire_a, 4'b1111};
                        x1 = m_dip[1] | {1'b1, right, left, fire_a, 1'b1, start1, start2, coin};
                        x2 = m_dip[2] | {1'b1, right, left, fire_a, 4'b0011};
                end
                8'd5:
                begin
                        x0 = m_dip[0] | {p1[4], 3'b010, p1[0], p1[1], p1[2], p1[3]};
                        x1 = m_dip[1] | {p2[4], 3'b010, p2[0], p2[1], p2[2], p2[3]};
                        x2 = m_dip[2] | {start1, coin, start1, 5'b01101};
                        x3 = shift_reverse ? bit_reverse(shifter_data) : shifter_data;
                end
                8'd14:
                begin
                        x0 = m_dip[0] | {p2[3], p2[2], p2[0], p2[1], p1[3], p1[2], p1[0], p1[1]};
                        x1 = m_dip[1] | {4'b0000, coin, 1'b0, start2, start1};
                        x2 = 8'h00;
                end
                8'd15:
                begin
                        x0 = m_dip[0] | {~coin, 4'b1111, ~fire_a, ~left, ~right};
                        x1 = 8'h00;
                        x2 = 8'h00;
                end
                default:
                        ;
                endcase
                // Trigger and cabinet tables
                case (m_game)
                8'd0:    {trg, land, rot, wd} = {port_wr[2], port_wr[4], port_wr[3],
                                                 port_wr[5], port_wr[6], 3'b011};
                8'd5:    {trg, land, rot, wd} = {port_wr[1], port_wr[2], port_wr[3],
                                                 port_wr[5], port_wr[4], 3'b101};
                8'd14:   {trg, land, rot, wd} = {port_wr[2], port_wr[4], port_wr[3],
                                                 port_wr[5], port_wr[6], 3'b100};
                8'd15:   {trg, land, rot, wd} = {port_wr[7], port_wr[3], port_wr[4],
                                                 port_wr[6], port_wr[5], 3'b010};
                default: {trg, land, rot, wd} = {port_wr[2], port_wr[4], port_wr[3],
                                                 port_wr[5], port_wr[6], 3'b101};
                endcase
                if (wide_aspect)
                        {ax, ay} = {8'd16, 8'd9};
                else if (horizontal_view | land)
                        {ax, ay} = {8'd4, 8'd3};
                else
                        {ax, ay} = {8'd3, 8'd4};
                return {x0, x1, x2, x3, trg, land, rot, wd, ax, ay};
        endfunction

        ////////////////////////////////////////
        // Stimulus and checking
        ////////////////////////////////////////
        task check_value(input string name, input logic [7:0] expv, input logic [7:0] actv);
                checks++;
                if (actv !== expv)
                begin
                        errors++;
                        $display("Fail at %0t: %s expected %h, got %h", $time, name, expv, actv);
                end
        endtask

        task drive_key(input logic [10:0] ev);
                int slot;
                @(posedge clk_sys);
                ps2_key <= ev;
                @(posedge clk_sys);
                slot = key_slot(ev[8:0]);
                if (ev[10] != key_tgl && slot >= 0)
                        kb[slot] = ev[9];
                key_tgl = ev[10];
        endtask

        task download(input logic [7:0] index, input logic [24:0] addr, input logic [7:0] data);
                @(posedge clk_sys);
                ioctl_wr    <= 1'b1;
                ioctl_index <= index;
                ioctl_addr  <= addr;
                ioctl_dout  <= data;
                @(posedge clk_sys);
                ioctl_wr <= 1'b0;
                if (index == 8'd1)
                        m_game = data;
                if (index == 8'd254 && addr < 4)
                        m_dip[addr[1:0]] = data;
        endtask

        task drive_random_inputs(input logic [7:0] wr_bits);
                logic [31:0] ra;
                logic [31:0] rb;
                ra = $urandom;
                rb = $urandom;
                @(posedge clk_sys);
                joy1            <= ra[15:0];
                joy2            <= ra[31:16];
                shifter_data    <= rb[7:0];
                shift_reverse   <= rb[8];
                wide_aspect     <= rb[9];
                horizontal_view <= rb[10];
                port_wr         <= wr_bits;
        endtask

        always @(negedge clk_sys)
        begin
                if (check_en)
                begin
                        exp_vec = expected_outputs();
                        check_value("port0", exp_vec[55:48], port0);
                        check_value("port1", exp_vec[47:40], port1);
                        check_value("port2", exp_vec[39:32], port2);
                        check_value("port3", exp_vec[31:24], port3);
                        check_value("shift_count", exp_vec[23], shift_count);
                        check_value("shift_data", exp_vec[22], shift_data);
                        check_value("audio_p1", exp_vec[21], audio_p1);
                        check_value("audio_p2", exp_vec[20], audio_p2);
                        check_value("watchdog_kick", exp_vec[19], watchdog_kick);
                        check_value("landscape", exp_vec[18], landscape);
                        check_value("rotate_ccw", exp_vec[17], rotate_ccw);
                        check_value("watchdog_enable", exp_vec[16], watchdog_enable);
                        check_value("hdmi_arx", exp_vec[15:8], hdmi_arx);
                        check_value("hdmi_ary", exp_vec[7:0], hdmi_ary);
                end
        end

        // Test length is about 600 cycles
        initial
        begin
                #(1200 * 10 * 2);
                $display("Timeout: the tests did not finish in the allowed time");
                $display("TEST FAILED");
                $finish;
        end

        initial
        begin
                r = $urandom(18);
                reset = 1'b1;
                ps2_key = '0;
                joy1 = '0;
                joy2 = '0;
                ioctl_wr = 1'b0;
                ioctl_index = 8'd0;
                ioctl_addr = '0;
                ioctl_dout = 8'd0;
                wide_aspect = 1'b0;
                horizontal_view = 1'b0;
                shifter_data = 8'd0;
                shift_reverse = 1'b0;
                port_wr = 8'd0;
                kb = '0;
                key_tgl = 1'b0;
                m_game = 8'd0;
                for (b = 0; b < 4; b++)
                        m_dip[b] = 8'd0;
                check_en = 1'b0;
                errors = 0;
                checks = 0;
                repeat (16) @(posedge clk_sys);
                reset <= 1'b0;
                check_en = 1'b1;

                // Reset state with random aspect selects
                repeat (6)
                begin
                        r = $urandom;
                        @(posedge clk_sys);
                        wide_aspect     <= r[0];
                        horizontal_view <= r[1];
                end

                // Keyboard events, some unknown codes and some stale toggles
                repeat (60)
                begin
                        r = $urandom;
                        if (r[1:0] == 2'b00)
                                code = r[12:4];
                        else
                                code = {1'b0, code_list[8 * (r[20:16] % 23) +: 8]};
                        tgl = (r[24:22] == 3'b000) ? key_tgl : ~key_tgl;
                        drive_key({tgl, r[25], code});
                end

                // DIP banks 0..7, wrong index and out of range address
                for (b = 0; b < 8; b++)
                begin
                        r = $urandom;
                        download(8'd254, b, r[7:0]);
                end
                download(8'd0, 25'd0, 8'hA5);
                download(8'd7, 25'd1, 8'h5A);
                download(8'd254, 25'h1000002, 8'hC3);
                drive_random_inputs(8'd0);

                // Every kept game plus one unknown number
                for (g = 0; g < 5; g++)
                begin
                        download(8'd1, 25'd0, game_list[8 * g +: 8]);
                        for (b = 0; b < 4; b++)
                        begin
                                r = $urandom;
                                download(8'd254, b, r[7:0] & r[15:8] & r[23:16]);
                        end
                        for (b = 0; b < 8; b++)
                                drive_random_inputs(8'd1 << b);
                        repeat (24)
                        begin
                                r = $urandom;
                                drive_random_inputs(r[7:0]);
                                if (r[9:8] == 2'b00)
                                        drive_key({~key_tgl, r[10],
                                                   1'b0, code_list[8 * (r[15:11] % 23) +: 8]});
                        end
                end

                repeat (2) @(posedge clk_sys);
                $display("Run complete: %0d errors in %0d checks", errors, checks);
                if (errors == 0)
                        $display("TEST PASSED");
                else
                        $display("TEST FAILED");
                $finish;
        end

endmodule

// File: logic/invaders_io_top.sv
// Invaders I/O top level joining control decode, cabinet config, input ports and triggers
`timescale 1ns/1ps

module invaders_io_top
(
        input  logic                               clk_sys,
        input  logic                               reset,
        input  logic [invaders_pkg::PS2_W-1:0]     ps2_key,
        input  logic [invaders_pkg::JOY_W-1:0]     joy1,
        input  logic [invaders_pkg::JOY_W-1:0]     joy2,
        input  logic                               ioctl_wr,
        input  invaders_pkg::byte_t                ioctl_index,
        input  logic [invaders_pkg::DL_ADDR_W-1:0] ioctl_addr,
        input  invaders_pkg::byte_t                ioctl_dout,
        input  logic                               wide_aspect,
        input  logic                               horizontal_view,
        input  invaders_pkg::byte_t                shifter_data,
        input  logic                               shift_reverse,
        input  invaders_pkg::byte_t                port_wr,
        output invaders_pkg::byte_t                port0,
        output invaders_pkg::byte_t                port1,
        output invaders_pkg::byte_t                port2,
        output invaders_pkg::byte_t                port3,
        output logic                               shift_count,
        output logic                               shift_data,
        output logic                               audio_p1,
        output logic                               audio_p2,
        output logic                               watchdog_kick,
        output logic                               landscape,
        output logic                               rotate_ccw,
        output logic                               watchdog_enable,
        output invaders_pkg::byte_t                hdmi_arx,
        output invaders_pkg::byte_t                hdmi_ary
);

        controls_if ctl ();
        config_if   cfg ();

        control_decoder u_control_decoder (
                .clk_sys (clk_sys),
                .reset   (reset),
                .ps2_key (ps2_key),
                .joy1    (joy1),
                .joy2    (joy2),
                .ctl     (ctl.source)
        );

        cabinet_config u_cabinet_config (
                .clk_sys         (clk_sys),
                .reset           (reset),
                .ioctl_wr        (ioctl_wr),
                .ioctl_index     (ioctl_index),
                .ioctl_addr      (ioctl_addr),
                .ioctl_dout      (ioctl_dout),
                .wide_aspect     (wide_aspect),
                .horizontal_view (horizontal_view),
                .cfg             (cfg.source),
                .landscape       (landscape),
                .rotate_ccw      (rotate_ccw),
                .watchdog_enable (watchdog_enable),
                .hdmi_arx        (hdmi_arx),
                .hdmi_ary        (hdmi_ary)
        );

        input_port_mux u_input_port_mux (
                .cfg           (cfg.sink),
                .ctl           (ctl.sink),
                .shifter_data  (shifter_data),
                .shift_reverse (shift_reverse),
                .port0         (port0),
                .port1         (port1),
                .port2         (port2),
                .port3         (port3)
        );

        port_trigger_router u_port_trigger_router (
                .cfg           (cfg.sink),
                .port_wr       (port_wr),
                .shift_count   (shift_count),
                .shift_data    (shift_data),
                .audio_p1      (audio_p1),
                .audio_p2      (audio_p2),
                .watchdog_kick (watchdog_kick)
        );

endmodule

// File: logic/port_trigger_router.sv
// Port trigger router mapping CPU port-write strobes to peripheral triggers per game
`timescale 1ns/1ps

module port_trigger_router
(
        config_if.sink              cfg,
        input  invaders_pkg::byte_t port_wr,
        output logic                shift_count,
        output logic                shift_data,
        output logic                audio_p1,
        output logic                audio_p2,
        output logic                watchdog_kick
);

        import invaders_pkg::*;

        // Order is count, audio1, data, audio2, watchdog
        logic [TRIG_COUNT-1:0] trig;

        always_comb
        begin
                case (cfg.game)
                GAME_BOOT_HILL:
                        trig = {port_wr[1], port_wr[3], port_wr[2], port_wr[5], port_wr[4]};
                GAME_ATTACK_FORCE:
                        trig = {port_wr[7], port_wr[4], port_wr[3], port_wr[6], port_wr[5]};
                // Standard Midway layout
                default:
                        trig = {port_wr[2], port_wr[3], port_wr[4], port_wr[5], port_wr[6]};
                endcase
        end

        assign shift_count   = trig[4];
        assign audio_p1      = trig[3];
        assign shift_data    = trig[2];
        assign audio_p2      = trig[1];
        assign watchdog_kick = trig[0];

endmodule

// File: logic/input_port_mux.sv
// Input port mux building the four CPU input ports for the selected game
`timescale 1ns/1ps

module input_port_mux
(
        config_if.sink              cfg,
        controls_if.sink            ctl,
        input  invaders_pkg::byte_t shifter_data,
        input  logic                shift_reverse,
        output invaders_pkg::byte_t port0,
        output invaders_pkg::byte_t port1,
        output invaders_pkg::byte_t port2,
        output invaders_pkg::byte_t port3
);

        import invaders_pkg::*;

        byte_t shifter_rev;

        // Bit reversed shifter result, read by the mirrored screen games
        assign shifter_rev = {<<{shifter_data}};

        always_comb
        begin
                port0 = 8'hFF;
                port1 = 8'hFF;
                port2 = 8'hFF;
                port3 = shifter_data;
                case (cfg.game)
                GAME_SPACE_INVADERS:
                begin
                        port0 = cfg.dip0 | {1'b1, ctl.right, ctl.left, ctl.fire_a, 4'b1111};
                        port1 = cfg.dip1 | {1'b1, ctl.right, ctl.left, ctl.fire_a,
                                            1'b1, ctl.start1, ctl.start2, ctl.coin};
                        port2 = cfg.dip2 | {1'b1, ctl.right, ctl.left, ctl.fire_a, 4'b0011};
                end
                GAME_BOOT_HILL:
                begin
                        // One port per gunslinger
                        port0 = cfg.dip0 | {ctl.p1_fire_a, 3'b010, ctl.p1_right,
                                            ctl.p1_left, ctl.p1_down, ctl.p1_up};
                        port1 = cfg.dip1 | {ctl.p2_fire_a, 3'b010, ctl.p2_right,
                                            ctl.p2_left, ctl.p2_down, ctl.p2_up};
                        port2 = cfg.dip2 | {ctl.start1, ctl.coin, ctl.start1, 5'b01101};
                        port3 = shift_reverse ? shifter_rev : shifter_data;
                end
                GAME_AMAZING_MAZE:
                begin
                        port0 = cfg.dip0 | {ctl.p2_up, ctl.p2_down, ctl.p2_right, ctl.p2_left,
                                            ctl.p1_up, ctl.p1_down, ctl.p1_right, ctl.p1_left};
                        port1 = cfg.dip1 | {4'b0000, ctl.coin, 1'b0, ctl.start2, ctl.start1};
                        port2 = 8'h00;
                end
                GAME_ATTACK_FORCE:
                begin
                        // Active low controls
                        port0 = cfg.dip0 | {~ctl.coin, 4'b1111, ~ctl.fire_a,
                                            ~ctl.left, ~ctl.right};
                        port1 = 8'h00;
                        port2 = 8'h00;
                end
                default:
                        ;
                endcase
        end

endmodule

// File: logic/cabinet_config.sv
// Cabinet configuration with game and DIP download registers, flags and HDMI aspect
`timescale 1ns/1ps

module cabinet_config
(
        input  logic                               clk_sys,
        input  logic                               reset,
        input  logic                               ioctl_wr,
        input  invaders_pkg::byte_t                ioctl_index,
        input  logic [invaders_pkg::DL_ADDR_W-1:0] ioctl_addr,
        input  invaders_pkg::byte_t                ioctl_dout,
        input  logic                               wide_aspect,
        input  logic                               horizontal_view,
        config_if.source                           cfg,
        output logic                               landscape,
        output logic                               rotate_ccw,
        output logic                               watchdog_enable,
        output invaders_pkg::byte_t                hdmi_arx,
        output invaders_pkg::byte_t                hdmi_ary
);

        import invaders_pkg::*;

        game_e game;
        byte_t dip [DIP_BANKS];

        ////////////////////////////////////////
        // Download registers
        ////////////////////////////////////////
        always_ff @(posedge clk_sys)
        begin
                if (reset)
                begin
                        game <= GAME_SPACE_INVADERS;
                        dip  <= '{default: '0};
                end
                else if (ioctl_wr)
                begin
                        if (ioctl_index == IDX_GAME)
                                game <= game_e'(ioctl_dout);
                        // Only the low banks are kept, the rest of the block is dropped
                        if (ioctl_index == IDX_DIP && ioctl_addr < DL_ADDR_W'(DIP_BANKS))
                                dip[ioctl_addr[1:0]] <= ioctl_dout;
                end
        end

        assign cfg.game = game;
        assign cfg.dip0 = dip[0];
        assign cfg.dip1 = dip[1];
        assign cfg.dip2 = dip[2];
        assign cfg.dip3 = dip[3];

        // Monitor orientation and watchdog per game
        always_comb
        begin
                landscape       = 1'b1;
                rotate_ccw      = 1'b0;
                watchdog_enable = 1'b1;
                case (game)
                GAME_SPACE_INVADERS:
                begin
                        landscape  = 1'b0;
                        rotate_ccw = 1'b1;
                end
                GAME_AMAZING_MAZE:
                        watchdog_enable = 1'b0;
                GAME_ATTACK_FORCE:
                begin
                        landscape       = 1'b0;
                        rotate_ccw      = 1'b1;
                        watchdog_enable = 1'b0;
                end
                default:
                        ;
                endcase
        end

        assign hdmi_arx = wide_aspect ? ASPECT_WIDE_X :
                          (horizontal_view | landscape) ? ASPECT_LAND_X : ASPECT_PORT_X;
        assign hdmi_ary = wide_aspect ? ASPECT_WIDE_Y :
                          (horizontal_view | landscape) ? ASPECT_LAND_Y : ASPECT_PORT_Y;

endmodule

// File: logic/control_decoder.sv
// Control decoder turning PS/2 key events into buttons merged with two joysticks
`timescale 1ns/1ps

module control_decoder
(
        input  logic                           clk_sys,
        input  logic                           reset,
        input  logic [invaders_pkg::PS2_W-1:0] ps2_key,
        input  logic [invaders_pkg::JOY_W-1:0] joy1,
        input  logic [invaders_pkg::JOY_W-1:0] joy2,
        controls_if.source                     ctl
);

        import invaders_pkg::*;

        typedef struct packed {
                logic p1_right, p1_left, p1_down, p1_up, p1_fire_a, p1_fire_b;
                logic p2_right, p2_left, p2_down, p2_up, p2_fire_a, p2_fire_b;
                logic coin1, coin2, start1, start2;
        } btn_t;

        btn_t                  btn;
        logic                  toggle_q;
        logic                  pressed;
        logic [PS2_CODE_W-1:0] code;
        logic [JOY_W-1:0]      joy_any;

        assign pressed = ps2_key[PS2_PRESS];
        assign code    = ps2_key[PS2_CODE_W-1:0];

        ////////////////////////////////////////
        // Keyboard buttons
        ////////////////////////////////////////
        // A new event is flagged by a flip of the toggle bit
        always_ff @(posedge clk_sys)
        begin
                if (reset)
                begin
                        toggle_q <= 1'b0;
                        btn      <= '0;
                end
                else
                begin
                        toggle_q <= ps2_key[PS2_TOGGLE];
                        if (ps2_key[PS2_TOGGLE] != toggle_q)
                        begin
                                case (code)
                                KEY_P1_UP:                   btn.p1_up     <= pressed;
                                KEY_P1_DOWN:                 btn.p1_down   <= pressed;
                                KEY_P1_LEFT:                 btn.p1_left   <= pressed;
                                KEY_P1_RIGHT:                btn.p1_right  <= pressed;
                                KEY_P1_FIRE_A:               btn.p1_fire_a <= pressed;
                                KEY_P1_FIRE_B:               btn.p1_fire_b <= pressed;
                                KEY_P2_UP:                   btn.p2_up     <= pressed;
                                KEY_P2_DOWN:                 btn.p2_down   <= pressed;
                                KEY_P2_LEFT:                 btn.p2_left   <= pressed;
                                KEY_P2_RIGHT:                btn.p2_right  <= pressed;
                                KEY_P2_FIRE_A:               btn.p2_fire_a <= pressed;
                                KEY_P2_FIRE_B:               btn.p2_fire_b <= pressed;
                                KEY_COIN1, KEY_COIN1_ALT:    btn.coin1     <= pressed;
                                KEY_COIN2:                   btn.coin2     <= pressed;
                                KEY_START1, KEY_START1_ALT:  btn.start1    <= pressed;
                                KEY_START2, KEY_START2_ALT:  btn.start2    <= pressed;
                                default:                     ;
                                endcase
                        end
                end
        end

        ////////////////////////////////////////
        // Joystick merge
        ////////////////////////////////////////
        // Joystick bits: 0 right, 1 left, 2 down, 3 up, 4..5 fire, 8..10 start and coin
        assign joy_any = joy1 | joy2;

        assign ctl.p1_right  = btn.p1_right  | joy1[0];
        assign ctl.p1_left   = btn.p1_left   | joy1[1];
        assign ctl.p1_down   = btn.p1_down   | joy1[2];
        assign ctl.p1_up     = btn.p1_up     | joy1[3];
        assign ctl.p1_fire_a = btn.p1_fire_a | joy1[4];
        assign ctl.p1_fire_b = btn.p1_fire_b | joy1[5];

        assign ctl.p2_right  = btn.p2_right  | joy2[0];
        assign ctl.p2_left   = btn.p2_left   | joy2[1];
        assign ctl.p2_down   = btn.p2_down   | joy2[2];
        assign ctl.p2_up     = btn.p2_up     | joy2[3];
        assign ctl.p2_fire_a = btn.p2_fire_a | joy2[4];
        assign ctl.p2_fire_b = btn.p2_fire_b | joy2[5];

        assign ctl.start1 = btn.start1 | joy_any[8];
        assign ctl.start2 = btn.start2 | joy_any[9];
        assign ctl.coin   = btn.coin1 | btn.coin2 | joy_any[10];

        // Either player, used by the single control games
        assign ctl.right  = ctl.p1_right  | ctl.p2_right;
        assign ctl.left   = ctl.p1_left   | ctl.p2_left;
        assign ctl.fire_a = ctl.p1_fire_a | ctl.p2_fire_a;

endmodule

// File: logic/cabinet_if.sv
// Cabinet interfaces carrying merged player controls and game configuration
`timescale 1ns/1ps

interface controls_if;

        // Per player levels
        logic p1_right, p1_left, p1_down, p1_up, p1_fire_a, p1_fire_b;
        logic p2_right, p2_left, p2_down, p2_up, p2_fire_a, p2_fire_b;

        // Shared and either-player levels
        logic start1, start2, coin;
        logic right, left, fire_a;

        modport source (output p1_right, p1_left, p1_down, p1_up, p1_fire_a, p1_fire_b,
                        p2_right, p2_left, p2_down, p2_up, p2_fire_a, p2_fire_b,
                        start1, start2, coin, right, left, fire_a);

        modport sink (input p1_right, p1_left, p1_down, p1_up, p1_fire_a, p1_fire_b,
                      p2_right, p2_left, p2_down, p2_up, p2_fire_a, p2_fire_b,
                      start1, start2, coin, right, left, fire_a);

endinterface

interface config_if;

        import invaders_pkg::*;

        game_e game;
        byte_t dip0;
        byte_t dip1;
        byte_t dip2;
        byte_t dip3;

        modport source (output game, dip0, dip1, dip2, dip3);
        modport sink (input game, dip0, dip1, dip2, dip3);

endinterface

// File: logic/invaders_pkg.sv
// Invaders I/O package with game numbers, scan codes, widths and aspect constants
package invaders_pkg;

        // Game select byte from the download stream
        typedef enum logic [7:0] {
                GAME_SPACE_INVADERS = 8'd0,
                GAME_BOOT_HILL      = 8'd5,
                GAME_AMAZING_MAZE   = 8'd14,
                GAME_ATTACK_FORCE   = 8'd15
        } game_e;

        typedef logic [7:0] byte_t;

        ////////////////////////////////////////
        // Download stream
        ////////////////////////////////////////
        localparam int unsigned DIP_BANKS = 4;
        localparam byte_t       IDX_ROM   = 8'd0;
        localparam byte_t       IDX_GAME  = 8'd1;
        localparam byte_t       IDX_DIP   = 8'd254;
        localparam int unsigned DL_ADDR_W = 25;

        ////////////////////////////////////////
        // Controls
        ////////////////////////////////////////
        localparam int unsigned JOY_W      = 16;
        localparam int unsigned PS2_W      = 11;
        localparam int unsigned PS2_TOGGLE = 10;
        localparam int unsigned PS2_PRESS  = 9;
        localparam int unsigned PS2_CODE_W = 9;

        // Scan codes, arrow keys plus the MAME style layout
        localparam logic [PS2_CODE_W-1:0] KEY_P1_UP      = 9'h075;
        localparam logic [PS2_CODE_W-1:0] KEY_P1_DOWN    = 9'h072;
        localparam logic [PS2_CODE_W-1:0] KEY_P1_LEFT    = 9'h06B;
        localparam logic [PS2_CODE_W-1:0] KEY_P1_RIGHT   = 9'h074;
        localparam logic [PS2_CODE_W-1:0] KEY_P1_FIRE_A  = 9'h014;
        localparam logic [PS2_CODE_W-1:0] KEY_P1_FIRE_B  = 9'h011;
        localparam logic [PS2_CODE_W-1:0] KEY_P2_UP      = 9'h02D;
        localparam logic [PS2_CODE_W-1:0] KEY_P2_DOWN    = 9'h02B;
        localparam logic [PS2_CODE_W-1:0] KEY_P2_LEFT    = 9'h023;
        localparam logic [PS2_CODE_W-1:0] KEY_P2_RIGHT   = 9'h034;
        localparam logic [PS2_CODE_W-1:0] KEY_P2_FIRE_A  = 9'h01C;
        localparam logic [PS2_CODE_W-1:0] KEY_P2_FIRE_B  = 9'h01B;
        localparam logic [PS2_CODE_W-1:0] KEY_COIN1      = 9'h076;
        localparam logic [PS2_CODE_W-1:0] KEY_COIN1_ALT  = 9'h02E;
        localparam logic [PS2_CODE_W-1:0] KEY_COIN2      = 9'h036;
        localparam logic [PS2_CODE_W-1:0] KEY_START1     = 9'h005;
        localparam logic [PS2_CODE_W-1:0] KEY_START1_ALT = 9'h016;
        localparam logic [PS2_CODE_W-1:0] KEY_START2     = 9'h006;
        localparam logic [PS2_CODE_W-1:0] KEY_START2_ALT = 9'h01E;

        ////////////////////////////////////////
        // Video aspect and triggers
        ////////////////////////////////////////
        localparam byte_t ASPECT_WIDE_X = 8'd16;
        localparam byte_t ASPECT_WIDE_Y = 8'd9;
        localparam byte_t ASPECT_LAND_X = 8'd4;
        localparam byte_t ASPECT_LAND_Y = 8'd3;
        localparam byte_t ASPECT_PORT_X = 8'd3;
        localparam byte_t ASPECT_PORT_Y = 8'd4;

        localparam int unsigned TRIG_COUNT = 5;

endpackage
